// ==== pad_pkg.sv ====
////////////////////////////////////////////////////////////
// Pad counts, attribute bit positions and attribute type
////////////////////////////////////////////////////////////

package pad_pkg;

  // Pad counts on the board
  parameter int NMioPads = 16;
  parameter int NDioPads = 4;

  // Attribute width per pad
  parameter int AttrDw = 2;

  // Attribute bit positions
  // Invert flips both the driven value and the sampled value
  parameter int AttrInvert    = 0;
  // Open drain releases the pad when the core drives a 1
  parameter int AttrOpenDrain = 1;

  // Per-pad attribute, indexed with the bit positions above
  typedef logic [AttrDw-1:0] pad_attr_t;

endpackage : pad_pkg

// ==== core_reg_pkg.sv ====
////////////////////////////////////////////////////////////
// Register address map and register port widths
////////////////////////////////////////////////////////////

package core_reg_pkg;

  // Register port widths
  parameter int RegAw = 4;
  parameter int RegDw = 16;

  // MIO registers
  parameter logic [RegAw-1:0] MioOutAddr = 4'd0;
  parameter logic [RegAw-1:0] MioOeAddr  = 4'd1;
  parameter logic [RegAw-1:0] MioInAddr  = 4'd2;

  // DIO registers, low bits only
  parameter logic [RegAw-1:0] DioOutAddr = 4'd3;
  parameter logic [RegAw-1:0] DioOeAddr  = 4'd4;
  parameter logic [RegAw-1:0] DioInAddr  = 4'd5;

  // Attribute registers
  parameter logic [RegAw-1:0] MioInvAddr = 4'd6;
  parameter logic [RegAw-1:0] MioOdAddr  = 4'd7;
  parameter logic [RegAw-1:0] DioInvAddr = 4'd8;
  parameter logic [RegAw-1:0] DioOdAddr  = 4'd9;

endpackage : core_reg_pkg

// ==== pad_if.sv ====
////////////////////////////////////////////////////////////
// Core to padring signals for one group of pads
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface pad_if #(
  parameter int NPads = 1
) ();

  import pad_pkg::*;

  // Driven by the register block
  logic [NPads-1:0] core_out;
  logic [NPads-1:0] core_oe;
  pad_attr_t [NPads-1:0] core_attr;

  // Synchronised pad values from the padring
  logic [NPads-1:0] core_in;

  modport core (
    output core_out,
    output core_oe,
    output core_attr,
    input  core_in
  );

  modport padring (
    input  core_out,
    input  core_oe,
    input  core_attr,
    output core_in
  );

endinterface : pad_if

// ==== rst_sync.sv ====
////////////////////////////////////////////////////////////
// Reset stretcher for the core reset
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rst_sync #(
  parameter int RstHoldCycles = 4
) (
  input  logic clk_main_i,
  input  logic rst_i,
  output logic rst_o
);

  localparam int CntW = (RstHoldCycles > 0) ? $clog2(RstHoldCycles + 1) : 1;

  logic [CntW-1:0] hold_cnt_q;
  logic            rst_q;

  // Counter reloads while board reset is high, then counts down
  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      hold_cnt_q <= CntW'(RstHoldCycles);
      rst_q      <= 1'b1;
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
      rst_q      <= 1'b1;
    end else begin
      rst_q      <= 1'b0;
    end
  end

  assign rst_o = rst_q;

endmodule : rst_sync

// ==== padring.sv ====
////////////////////////////////////////////////////////////
// Padring for one pad group: attributes, connect masking
// and a two-flop input synchroniser
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module padring #(
  parameter int               NPads       = 1,
  parameter logic [NPads-1:0] ConnectMask = '1
) (
  input  logic             clk_main_i,
  input  logic             rst_i,
  input  logic [NPads-1:0] pad_in_i,
  output logic [NPads-1:0] pad_out_o,
  output logic [NPads-1:0] pad_oe_o,
  pad_if.padring           core
);

  import pad_pkg::*;

  logic [NPads-1:0] in_meta_q;
  logic [NPads-1:0] in_sync_q;
  logic [NPads-1:0] attr_inv;
  logic [NPads-1:0] attr_od;

  ////////////////////////////////////////////////////////////
  // Attribute split
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NPads; i++) begin
      attr_inv[i] = core.core_attr[i][AttrInvert];
      attr_od[i]  = core.core_attr[i][AttrOpenDrain];
    end
  end

  ////////////////////////////////////////////////////////////
  // Output path
  ////////////////////////////////////////////////////////////

  // Open drain only drives the low level
  assign pad_out_o = ConnectMask & (core.core_out ^ attr_inv);
  assign pad_oe_o  = ConnectMask & core.core_oe & ~(attr_od & core.core_out);

  ////////////////////////////////////////////////////////////
  // Input path
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      in_meta_q <= pad_in_i;
      in_sync_q <= in_meta_q;
    end
  end

  // Unconnected pads read back as 0
  assign core.core_in = ConnectMask & (in_sync_q ^ attr_inv);

endmodule : padring

// ==== core_regs.sv ====
////////////////////////////////////////////////////////////
// Core register file for pad out, oe, attributes and
// input readback, with a strobe read/write port
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module core_regs #(
  parameter int NMio = 16,
  parameter int NDio = 4
) (
  input  logic                           clk_main_i,
  input  logic                           rst_i,
  input  logic                           wr_en_i,
  input  logic                           rd_en_i,
  input  logic [core_reg_pkg::RegAw-1:0] addr_i,
  input  logic [core_reg_pkg::RegDw-1:0] wdata_i,
  output logic [core_reg_pkg::RegDw-1:0] rd_data_o,
  output logic                           rd_valid_o,
  pad_if.core                            mio,
  pad_if.core                            dio
);

  import pad_pkg::*;
  import core_reg_pkg::*;

  logic [NMio-1:0] mio_out_q;
  logic [NMio-1:0] mio_oe_q;
  logic [NMio-1:0] mio_inv_q;
  logic [NMio-1:0] mio_od_q;
  logic [NDio-1:0] dio_out_q;
  logic [NDio-1:0] dio_oe_q;
  logic [NDio-1:0] dio_inv_q;
  logic [NDio-1:0] dio_od_q;

  logic [RegDw-1:0] rd_mux;
  logic [RegDw-1:0] rd_data_q;
  logic             rd_valid_q;

  ////////////////////////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////////////////////////

  // Read-only and unknown addresses fall through untouched
  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      mio_out_q <= '0;
      mio_oe_q  <= '0;
      mio_inv_q <= '0;
      mio_od_q  <= '0;
      dio_out_q <= '0;
      dio_oe_q  <= '0;
      dio_inv_q <= '0;
      dio_od_q  <= '0;
    end else if (wr_en_i) begin
      case (addr_i)
        MioOutAddr: mio_out_q <= wdata_i[NMio-1:0];
        MioOeAddr:  mio_oe_q  <= wdata_i[NMio-1:0];
        MioInvAddr: mio_inv_q <= wdata_i[NMio-1:0];
        MioOdAddr:  mio_od_q  <= wdata_i[NMio-1:0];
        DioOutAddr: dio_out_q <= wdata_i[NDio-1:0];
        DioOeAddr:  dio_oe_q  <= wdata_i[NDio-1:0];
        DioInvAddr: dio_inv_q <= wdata_i[NDio-1:0];
        DioOdAddr:  dio_od_q  <= wdata_i[NDio-1:0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (addr_i)
      MioOutAddr: rd_mux = RegDw'(mio_out_q);
      MioOeAddr:  rd_mux = RegDw'(mio_oe_q);
      MioInAddr:  rd_mux = RegDw'(mio.core_in);
      DioOutAddr: rd_mux = RegDw'(dio_out_q);
      DioOeAddr:  rd_mux = RegDw'(dio_oe_q);
      DioInAddr:  rd_mux = RegDw'(dio.core_in);
      MioInvAddr: rd_mux = RegDw'(mio_inv_q);
      MioOdAddr:  rd_mux = RegDw'(mio_od_q);
      DioInvAddr: rd_mux = RegDw'(dio_inv_q);
      DioOdAddr:  rd_mux = RegDw'(dio_od_q);
      default:    rd_mux = '0;
    endcase
  end

  // Sampled at the strobe edge, so a same-cycle write is not seen
  always_ff @(posedge clk_main_i) begin
    if (rst_i) begin
      rd_data_q  <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_en_i;
      if (rd_en_i) begin
        rd_data_q <= rd_mux;
      end
    end
  end

  assign rd_data_o  = rd_data_q;
  assign rd_valid_o = rd_valid_q;

  ////////////////////////////////////////////////////////////
  // Drive the pad groups
  ////////////////////////////////////////////////////////////

  assign mio.core_out = mio_out_q;
  assign mio.core_oe  = mio_oe_q;
  assign dio.core_out = dio_out_q;
  assign dio.core_oe  = dio_oe_q;

  // Pack attribute bits per pad
  always_comb begin
    for (int i = 0; i < NMio; i++) begin
      mio.core_attr[i][AttrInvert]    = mio_inv_q[i];
      mio.core_attr[i][AttrOpenDrain] = mio_od_q[i];
    end
    for (int j = 0; j < NDio; j++) begin
      dio.core_attr[j][AttrInvert]    = dio_inv_q[j];
      dio.core_attr[j][AttrOpenDrain] = dio_od_q[j];
    end
  end

endmodule : core_regs

// ==== chip_top.sv ====
////////////////////////////////////////////////////////////
// Board-level top: reset stretcher, core registers and
// the MIO and DIO padrings
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module chip_top #(
  parameter logic [pad_pkg::NMioPads-1:0] ConnectMio    = 16'h00FF,
  parameter logic [pad_pkg::NDioPads-1:0] ConnectDio    = 4'hB,
  parameter int                           RstHoldCycles = 4
) (
  input  logic                           clk_main_i,
  input  logic                           rst_i,
  // Register port
  input  logic                           wr_en_i,
  input  logic                           rd_en_i,
  input  logic [core_reg_pkg::RegAw-1:0] addr_i,
  input  logic [core_reg_pkg::RegDw-1:0] wdata_i,
  output logic [core_reg_pkg::RegDw-1:0] rd_data_o,
  output logic                           rd_valid_o,
  // MIO pads
  input  logic [pad_pkg::NMioPads-1:0]   mio_pad_in_i,
  output logic [pad_pkg::NMioPads-1:0]   mio_pad_out_o,
  output logic [pad_pkg::NMioPads-1:0]   mio_pad_oe_o,
  // DIO pads
  input  logic [pad_pkg::NDioPads-1:0]   dio_pad_in_i,
  output logic [pad_pkg::NDioPads-1:0]   dio_pad_out_o,
  output logic [pad_pkg::NDioPads-1:0]   dio_pad_oe_o
);

  import pad_pkg::*;

  logic core_rst;

  pad_if #(.NPads(NMioPads)) mio_bus ();
  pad_if #(.NPads(NDioPads)) dio_bus ();

  ////////////////////////////////////////////////////////////
  // Reset and core
  ////////////////////////////////////////////////////////////

  rst_sync #(
    .RstHoldCycles ( RstHoldCycles )
  ) rst_sync_i (
    .clk_main_i ( clk_main_i ),
    .rst_i      ( rst_i      ),
    .rst_o      ( core_rst   )
  );

  core_regs #(
    .NMio ( NMioPads ),
    .NDio ( NDioPads )
  ) core_regs_i (
    .clk_main_i ( clk_main_i ),
    .rst_i      ( core_rst   ),
    .wr_en_i    ( wr_en_i    ),
    .rd_en_i    ( rd_en_i    ),
    .addr_i     ( addr_i     ),
    .wdata_i    ( wdata_i    ),
    .rd_data_o  ( rd_data_o  ),
    .rd_valid_o ( rd_valid_o ),
    .mio        ( mio_bus    ),
    .dio        ( dio_bus    )
  );

  ////////////////////////////////////////////////////////////
  // Padrings
  ////////////////////////////////////////////////////////////

  padring #(
    .NPads       ( NMioPads   ),
    .ConnectMask ( ConnectMio )
  ) mio_padring_i (
    .clk_main_i ( clk_main_i    ),
    .rst_i      ( core_rst      ),
    .pad_in_i   ( mio_pad_in_i  ),
    .pad_out_o  ( mio_pad_out_o ),
    .pad_oe_o   ( mio_pad_oe_o  ),
    .core       ( mio_bus       )
  );

  padring #(
    .NPads       ( NDioPads   ),
    .ConnectMask ( ConnectDio )
  ) dio_padring_i (
    .clk_main_i ( clk_main_i    ),
    .rst_i      ( core_rst      ),
    .pad_in_i   ( dio_pad_in_i  ),
    .pad_out_o  ( dio_pad_out_o ),
    .pad_oe_o   ( dio_pad_oe_o  ),
    .core       ( dio_bus       )
  );

endmodule : chip_top

// ==== tb_chip_top.sv ====
////////////////////////////////////////////////////////////
// chip_top testbench with pad wire model, register
// stimulus, assertions, watchdog and result report
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_chip_top;

  import pad_pkg::*;
  import core_reg_pkg::*;

  localparam logic [NMioPads-1:0] ConnectMio    = 16'h00FF;
  localparam logic [NDioPads-1:0] ConnectDio    = 4'hB;
  localparam int                  RstHoldCycles = 4;
  localparam int                  ClkPeriod     = 40;
  localparam int                  TimeoutCycles = 2000;

  logic                clk = 1'b0;
  logic                rst;
  logic                wr_en;
  logic                rd_en;
  logic [RegAw-1:0]    addr;
  logic [RegDw-1:0]    wdata;
  logic [RegDw-1:0]    rd_data;
  logic                rd_valid;
  logic [NMioPads-1:0] mio_pad_in;
  logic [NMioPads-1:0] mio_pad_out;
  logic [NMioPads-1:0] mio_pad_oe;
  logic [NMioPads-1:0] mio_ext;
  logic [NDioPads-1:0] dio_pad_in;
  logic [NDioPads-1:0] dio_pad_out;
  logic [NDioPads-1:0] dio_pad_oe;
  logic [NDioPads-1:0] dio_ext;

  logic [31:0]      rng_state = 32'h1212;
  logic [RegDw-1:0] shadow [0:9];
  int               error_count = 0;
  int               check_count = 0;
  int               test_errors = 0;

  always #(ClkPeriod / 2) clk = ~clk;

  // Pad wire carries the DUT value when oe is high and the board value otherwise
  assign mio_pad_in = (mio_pad_oe & mio_pad_out) | (~mio_pad_oe & mio_ext);
  assign dio_pad_in = (dio_pad_oe & dio_pad_out) | (~dio_pad_oe & dio_ext);

  chip_top #(
    .ConnectMio    ( ConnectMio    ),
    .ConnectDio    ( ConnectDio    ),
    .RstHoldCycles ( RstHoldCycles )
  ) chip_top_i (
    .clk_main_i    ( clk         ),
    .rst_i         ( rst         ),
    .wr_en_i       ( wr_en       ),
    .rd_en_i       ( rd_en       ),
    .addr_i        ( addr        ),
    .wdata_i       ( wdata       ),
    .rd_data_o     ( rd_data     ),
    .rd_valid_o    ( rd_valid    ),
    .mio_pad_in_i  ( mio_pad_in  ),
    .mio_pad_out_o ( mio_pad_out ),
    .mio_pad_oe_o  ( mio_pad_oe  ),
    .dio_pad_in_i  ( dio_pad_in  ),
    .dio_pad_out_o ( dio_pad_out ),
    .dio_pad_oe_o  ( dio_pad_oe  )
  );

  // Read valid is the read strobe delayed by one cycle
  read_valid_timing: assert property (@(posedge clk) disable iff (rst)
    rd_valid == $past(rd_en))
    else begin
      error_count = error_count + 1;
      $display("** Error at %0t: rd_valid does not follow rd_en by one cycle", $time);
    end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [RegDw-1:0] next_random();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[31:16];
  endfunction

  // Register model that keeps only the low DIO bits
  function automatic void track_write(input logic [RegAw-1:0] a, input logic [RegDw-1:0] d);
    case (a)
      MioOutAddr, MioOeAddr, MioInvAddr, MioOdAddr: shadow[a] = d;
      DioOutAddr, DioOeAddr, DioInvAddr, DioOdAddr: shadow[a] = d & 16'h000F;
      default: ;
    endcase
  endfunction

  // Expected MIO enables, pad by pad
  function automatic logic [RegDw-1:0] open_drain_oe(input logic [RegDw-1:0] oe,
                                                     input logic [RegDw-1:0] od,
                                                     input logic [RegDw-1:0] out);
    logic [RegDw-1:0] e;
    e = '0;
    for (int i = 0; i < NMioPads; i++) begin
      if (!ConnectMio[i]) begin
        e[i] = 1'b0;
      end else if (od[i] && out[i]) begin
        // Released pad
        e[i] = 1'b0;
      end else begin
        e[i] = oe[i];
      end
    end
    return e;
  endfunction

  task automatic expect_equal(input logic [RegDw-1:0] got, input logic [RegDw-1:0] exp,
                              input string what);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Pads and read valid stay low while the core is held in reset
  task automatic check_idle_outputs();
    expect_equal(mio_pad_oe, '0, "mio oe after reset");
    expect_equal(mio_pad_out, '0, "mio out after reset");
    expect_equal(RegDw'(dio_pad_oe), '0, "dio oe after reset");
    expect_equal(RegDw'(rd_valid), '0, "rd_valid after reset");
  endtask

  // One strobe cycle, result sampled mid-cycle after the next edge
  task automatic register_access(input logic do_write, input logic do_read,
                                 input logic [RegAw-1:0] a, input logic [RegDw-1:0] d,
                                 output logic [RegDw-1:0] q);
    @(posedge clk);
    wr_en <= do_write;
    rd_en <= do_read;
    addr  <= a;
    wdata <= d;
    @(posedge clk);
    wr_en <= 1'b0;
    rd_en <= 1'b0;
    if (do_write) begin
      track_write(a, d);
    end
    @(negedge clk);
    q = rd_data;
    if (do_read) begin
      check_count++;
      assert (rd_valid) else begin
        error_count++;
        $display("Read of address %0d at %0t got no valid pulse", a, $time);
      end
    end
  endtask

  task automatic check_read(input logic [RegAw-1:0] a, input logic [RegDw-1:0] exp,
                            input string what);
    logic [RegDw-1:0] q;
    register_access(1'b0, 1'b1, a, '0, q);
    expect_equal(q, exp, what);
  endtask

  // Change the board values, then let the synchroniser settle
  task automatic drive_external(input logic [NMioPads-1:0] m, input logic [NDioPads-1:0] d);
    @(posedge clk);
    mio_ext <= m;
    dio_ext <= d;
    repeat (2) @(posedge clk);
  endtask

  task automatic finish_test(input string name);
    $display("Test %-10s done with %0d errors", name, error_count - test_errors);
    test_errors = error_count;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    logic [RegDw-1:0] r_out;
    logic [RegDw-1:0] r_oe;
    logic [RegDw-1:0] r_inv;
    logic [RegDw-1:0] r_od;
    logic [RegDw-1:0] r_ext;
    logic [RegDw-1:0] r_dext;
    logic [RegDw-1:0] old;
    logic [RegDw-1:0] q;
    logic [RegDw-1:0] exp_oe;
    rst     = 1'b1;
    wr_en   = 1'b0;
    rd_en   = 1'b0;
    addr    = '0;
    wdata   = '0;
    mio_ext = '0;
    dio_ext = '0;
    for (int i = 0; i < 10; i++) begin
      shadow[i] = '0;
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // 1. Reset and hold period, with a write that the held core ignores
    wr_en <= 1'b1;
    addr  <= MioOeAddr;
    wdata <= 16'hFFFF;
    repeat (RstHoldCycles) begin
      @(negedge clk);
      check_idle_outputs();
    end
    @(posedge clk);
    wr_en <= 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_idle_outputs();
    end
    for (int i = 0; i < 10; i++) begin
      check_read(RegAw'(i), '0, "reset value");
    end
    finish_test("reset");

    // 2. Plain outputs and connect masks
    r_out = next_random();
    r_oe  = next_random();
    register_access(1'b1, 1'b0, MioOutAddr, r_out, q);
    expect_equal(mio_pad_out, r_out & ConnectMio, "mio out");
    register_access(1'b1, 1'b0, MioOeAddr, r_oe, q);
    expect_equal(mio_pad_oe, r_oe & ConnectMio, "mio oe");
    register_access(1'b1, 1'b0, DioOutAddr, 16'h000F, q);
    expect_equal(RegDw'(dio_pad_out), RegDw'(ConnectDio), "dio out");
    register_access(1'b1, 1'b0, DioOeAddr, next_random(), q);
    expect_equal(RegDw'(dio_pad_oe), shadow[DioOeAddr] & RegDw'(ConnectDio), "dio oe");
    finish_test("outputs");

    // 3. Inversion on both directions
    r_inv  = next_random();
    r_ext  = next_random();
    r_dext = next_random();
    register_access(1'b1, 1'b0, MioInvAddr, r_inv, q);
    expect_equal(mio_pad_out, (r_out ^ r_inv) & ConnectMio, "inverted mio out");
    register_access(1'b1, 1'b0, MioOeAddr, '0, q);
    register_access(1'b1, 1'b0, DioOeAddr, '0, q);
    register_access(1'b1, 1'b0, DioInvAddr, 16'h0006, q);
    drive_external(r_ext, r_dext[NDioPads-1:0]);
    check_read(MioInAddr, (r_ext ^ r_inv) & ConnectMio, "inverted mio in");
    check_read(DioInAddr, (r_dext ^ 16'h0006) & RegDw'(ConnectDio), "inverted dio in");
    finish_test("invert");

    // 4. Open drain with a board pull-up
    r_od  = next_random();
    r_out = next_random();
    r_oe  = next_random();
    register_access(1'b1, 1'b0, MioInvAddr, '0, q);
    register_access(1'b1, 1'b0, MioOdAddr, r_od, q);
    register_access(1'b1, 1'b0, MioOutAddr, r_out, q);
    register_access(1'b1, 1'b0, MioOeAddr, r_oe, q);
    exp_oe = open_drain_oe(r_oe, r_od, r_out);
    expect_equal(mio_pad_oe, exp_oe, "open drain oe");
    expect_equal(mio_pad_out, r_out & ConnectMio, "open drain out");
    drive_external(16'hFFFF, 4'hF);
    check_read(MioInAddr, ((exp_oe & r_out) | ~exp_oe) & ConnectMio, "open drain mio in");
    finish_test("opendrain");

    // 5. Read protocol and ignored writes
    for (int i = 10; i < 16; i++) begin
      check_read(RegAw'(i), '0, "unknown address");
    end
    register_access(1'b1, 1'b0, DioOdAddr, next_random(), q);
    register_access(1'b1, 1'b0, MioInAddr, next_random(), q);
    register_access(1'b1, 1'b0, DioInAddr, next_random(), q);
    register_access(1'b1, 1'b0, 4'd10, next_random(), q);
    register_access(1'b1, 1'b0, 4'd15, next_random(), q);
    for (int i = 0; i < 10; i++) begin
      if (i != int'(MioInAddr) && i != int'(DioInAddr)) begin
        check_read(RegAw'(i), shadow[i], "register readback");
      end
    end
    old = shadow[MioOeAddr];
    register_access(1'b1, 1'b1, MioOeAddr, next_random(), q);
    expect_equal(q, old, "read during write");
    check_read(MioOeAddr, shadow[MioOeAddr], "value after read during write");
    finish_test("protocol");

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TimeoutCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles, tests did not complete", TimeoutCycles);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule : tb_chip_top

// ==== verilog.f ====
pad_pkg.sv
core_reg_pkg.sv
pad_if.sv
rst_sync.sv
padring.sv
core_regs.sv
chip_top.sv
tb_chip_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_chip_top
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation incomplete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
